// ==== Makefile ====
TOP := tb_mem_subsys

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f all.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== all.f ====
core_pkg.sv
wb_if.sv
mem_stage.sv
fetch_unit.sv
wb_arbiter.sv
data_ram.sv
mem_subsys_top.sv
tb_mem_subsys.sv

// ==== core_pkg.sv ====
package core_pkg;

  localparam int DATA_WIDTH = 32;
  localparam int ADDR_WIDTH = 32;                    // Byte address
  localparam int REG_WIDTH  = 5;
  localparam int MEM_WORDS  = 256;
  localparam int MEM_AW     = $clog2(MEM_WORDS);     // Word index bits
  localparam int SEL_WIDTH  = DATA_WIDTH / 8;

  typedef enum logic [1:0] {
    SIZE_BYTE = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_WORD = 2'b10
  } access_size_t;

endpackage : core_pkg

// ==== data_ram.sv ====
module data_ram (
  input  logic clk_i,
  input  logic rst_i,
  wb_if.slave  bus_i
);

  logic [core_pkg::DATA_WIDTH-1:0] mem [core_pkg::MEM_WORDS];
  logic [core_pkg::MEM_AW-1:0]     idx;
  logic [core_pkg::DATA_WIDTH-1:0] rd_q;
  logic                            ack_q;
  logic                            access;

  assign idx    = bus_i.adr[core_pkg::MEM_AW+1:2];
  assign access = bus_i.cyc && bus_i.stb && !ack_q;   // New transfer

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (bus_i.we) begin
        for (int b = 0; b < core_pkg::SEL_WIDTH; b++) begin
          if (bus_i.sel[b]) mem[idx][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
        end
      end
      rd_q <= mem[idx];
    end
  end

  assign bus_i.ack   = ack_q;
  assign bus_i.dat_r = rd_q;

endmodule : data_ram

// ==== fetch_unit.sv ====
module fetch_unit (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic                            fetch_en_i,
  input  logic                            redirect_i,
  input  logic                            instr_ready_i,
  input  logic [core_pkg::ADDR_WIDTH-1:0] redirect_pc_i,
  output logic                            instr_valid_o,
  output logic [core_pkg::DATA_WIDTH-1:0] instr_o,
  output logic [core_pkg::ADDR_WIDTH-1:0] instr_pc_o,
  wb_if.master                            bus_o
);

  logic [core_pkg::ADDR_WIDTH-1:0] pc;
  logic                            busy;       // Read in flight
  logic                            stale;      // In-flight read predates a redirect
  logic                            buf_valid;
  logic [core_pkg::DATA_WIDTH-1:0] buf_instr;
  logic [core_pkg::ADDR_WIDTH-1:0] buf_pc;     // Also the address of the open read
  logic                            issue;
  logic                            fill;

  assign issue = !busy && fetch_en_i && !buf_valid && !redirect_i;
  assign fill  = busy && bus_o.ack && !stale && !redirect_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc        <= '0;
      busy      <= 1'b0;
      stale     <= 1'b0;
      buf_valid <= 1'b0;
    end else begin
      if (buf_valid && instr_ready_i) buf_valid <= 1'b0;
      if (busy && bus_o.ack) begin
        busy  <= 1'b0;
        stale <= 1'b0;
      end else if (issue) begin
        busy <= 1'b1;
      end
      if (fill) begin
        buf_valid <= 1'b1;
        pc        <= pc + 4;
      end
      if (redirect_i) begin
        pc        <= redirect_pc_i;
        buf_valid <= 1'b0;
        stale     <= busy && !bus_o.ack;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) buf_pc <= pc;
    if (fill) buf_instr <= bus_o.dat_r;
  end

  assign bus_o.cyc   = busy;
  assign bus_o.stb   = busy;
  assign bus_o.we    = 1'b0;
  assign bus_o.adr   = buf_pc;
  assign bus_o.sel   = '1;
  assign bus_o.dat_w = '0;

  assign instr_valid_o = buf_valid;
  assign instr_o       = buf_instr;
  assign instr_pc_o    = buf_pc;

endmodule : fetch_unit

// ==== mem_stage.sv ====
module mem_stage (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic [core_pkg::DATA_WIDTH-1:0] alu_result_i,
  input  logic [core_pkg::DATA_WIDTH-1:0] rs2_data_i,
  input  logic [core_pkg::REG_WIDTH-1:0]  wr_reg_i,
  input  logic                            valid_i,
  input  logic                            is_load_i,
  input  logic                            is_store_i,
  input  logic                            reg_wr_en_i,
  input  core_pkg::access_size_t          access_size_i,
  output logic                            stall_o,
  output logic                            wb_valid_o,
  output logic                            wb_reg_wr_en_o,
  output logic                            wb_is_load_o,
  output logic                            wb_is_next_cycle_o,
  output logic [core_pkg::REG_WIDTH-1:0]  wb_wr_reg_o,
  output logic [core_pkg::DATA_WIDTH-1:0] wb_alu_result_o,
  output logic [core_pkg::DATA_WIDTH-1:0] wb_load_data_o,
  wb_if.master                            bus_o
);

  typedef enum logic [1:0] {
    IDLE    = 2'b00,
    READY   = 2'b01,
    WAITING = 2'b10
  } state_t;

  state_t state, state_d;

  logic                            wb_valid_d;
  logic                            wb_reg_wr_en_d;
  logic                            latch_req;
  logic [core_pkg::DATA_WIDTH-1:0] load_data;
  logic [core_pkg::DATA_WIDTH-1:0] lane_data;

  // Open request, held stable for the bus
  logic [core_pkg::ADDR_WIDTH-1:0] req_adr;
  logic                            req_we;
  logic                            req_is_load;
  logic [core_pkg::SEL_WIDTH-1:0]  req_sel;
  logic [core_pkg::DATA_WIDTH-1:0] req_dat;
  logic [core_pkg::REG_WIDTH-1:0]  req_wr_reg;
  core_pkg::access_size_t          req_size;

  logic [core_pkg::SEL_WIDTH-1:0]  sel_d;
  logic [core_pkg::DATA_WIDTH-1:0] dat_d;

  always_comb begin : lane_encode
    case (access_size_i)
      core_pkg::SIZE_BYTE: begin
        sel_d = core_pkg::SEL_WIDTH'(1) << alu_result_i[1:0];
        dat_d = rs2_data_i << {alu_result_i[1:0], 3'b000};
      end
      core_pkg::SIZE_HALF: begin
        sel_d = alu_result_i[1] ? 4'b1100 : 4'b0011;
        dat_d = rs2_data_i << {alu_result_i[1], 4'b0000};
      end
      default: begin
        sel_d = '1;                                  // Word ignores low bits
        dat_d = rs2_data_i;
      end
    endcase
  end

  always_comb begin : lane_extract
    lane_data = bus_o.dat_r >> {req_adr[1:0], 3'b000};
    case (req_size)
      core_pkg::SIZE_BYTE: load_data = {{24{lane_data[7]}}, lane_data[7:0]};
      core_pkg::SIZE_HALF: begin
        lane_data = bus_o.dat_r >> {req_adr[1], 4'b0000};
        load_data = {{16{lane_data[15]}}, lane_data[15:0]};
      end
      default:             load_data = bus_o.dat_r;
    endcase
  end

  always_comb begin : state_update
    wb_valid_d     = 1'b0;
    wb_reg_wr_en_d = 1'b0;
    stall_o        = 1'b0;
    latch_req      = 1'b0;
    state_d        = state;

    case (state)
      IDLE: begin
        stall_o = valid_i;                           // Nothing accepted yet
        state_d = READY;
      end
      READY: begin
        if (valid_i) begin
          if (is_load_i || is_store_i) begin
            stall_o   = 1'b1;
            latch_req = 1'b1;
            state_d   = WAITING;
          end else begin
            wb_valid_d     = 1'b1;
            wb_reg_wr_en_d = reg_wr_en_i;
          end
        end
      end
      WAITING: begin
        stall_o = 1'b1;
        if (bus_o.ack) begin
          stall_o        = 1'b0;
          wb_valid_d     = 1'b1;
          wb_reg_wr_en_d = req_is_load;              // Stores write no register
          state_d        = READY;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin : ctrl_flops
    if (!rst_i) begin
      state          <= IDLE;
      wb_valid_o     <= 1'b0;
      wb_reg_wr_en_o <= 1'b0;
    end else begin
      state          <= state_d;
      wb_valid_o     <= wb_valid_d;
      wb_reg_wr_en_o <= wb_reg_wr_en_d;
    end
  end

  always_ff @(posedge clk_i) begin : data_flops
    if (latch_req) begin
      req_adr     <= alu_result_i;
      req_we      <= is_store_i;
      req_is_load <= is_load_i;
      req_sel     <= sel_d;
      req_dat     <= dat_d;
      req_wr_reg  <= wr_reg_i;
      req_size    <= access_size_i;
    end
    if (state == WAITING) begin
      wb_is_load_o    <= req_is_load;
      wb_wr_reg_o     <= req_wr_reg;
      wb_alu_result_o <= req_adr;
    end else begin
      wb_is_load_o    <= is_load_i;
      wb_wr_reg_o     <= wr_reg_i;
      wb_alu_result_o <= alu_result_i;
    end
    wb_load_data_o <= load_data;
  end

  assign bus_o.cyc   = (state == WAITING);
  assign bus_o.stb   = (state == WAITING);
  assign bus_o.we    = req_we;
  assign bus_o.adr   = req_adr;
  assign bus_o.sel   = req_sel;
  assign bus_o.dat_w = req_dat;

  assign wb_is_next_cycle_o = wb_valid_d;

endmodule : mem_stage

// ==== mem_subsys_top.sv ====
module mem_subsys_top (
  input  logic                            clk_i,
  input  logic                            rst_i,
  input  logic [core_pkg::DATA_WIDTH-1:0] alu_result_i,
  input  logic [core_pkg::DATA_WIDTH-1:0] rs2_data_i,
  input  logic [core_pkg::REG_WIDTH-1:0]  wr_reg_i,
  input  logic                            valid_i,
  input  logic                            is_load_i,
  input  logic                            is_store_i,
  input  logic                            reg_wr_en_i,
  input  core_pkg::access_size_t          access_size_i,
  output logic                            stall_o,
  output logic                            wb_valid_o,
  output logic                            wb_reg_wr_en_o,
  output logic                            wb_is_load_o,
  output logic                            wb_is_next_cycle_o,
  output logic [core_pkg::REG_WIDTH-1:0]  wb_wr_reg_o,
  output logic [core_pkg::DATA_WIDTH-1:0] wb_alu_result_o,
  output logic [core_pkg::DATA_WIDTH-1:0] wb_load_data_o,
  input  logic                            fetch_en_i,
  input  logic                            redirect_i,
  input  logic                            instr_ready_i,
  input  logic [core_pkg::ADDR_WIDTH-1:0] redirect_pc_i,
  output logic                            instr_valid_o,
  output logic [core_pkg::DATA_WIDTH-1:0] instr_o,
  output logic [core_pkg::ADDR_WIDTH-1:0] instr_pc_o
);

  wb_if m0_bus ();     // Memory stage
  wb_if m1_bus ();     // Instruction fetch
  wb_if ram_bus ();

  mem_stage u_mem (
    .clk_i, .rst_i, .alu_result_i, .rs2_data_i, .wr_reg_i, .valid_i,
    .is_load_i, .is_store_i, .reg_wr_en_i, .access_size_i, .stall_o,
    .wb_valid_o, .wb_reg_wr_en_o, .wb_is_load_o, .wb_is_next_cycle_o,
    .wb_wr_reg_o, .wb_alu_result_o, .wb_load_data_o,
    .bus_o (m0_bus)
  );

  fetch_unit u_fetch (
    .clk_i, .rst_i, .fetch_en_i, .redirect_i, .instr_ready_i, .redirect_pc_i,
    .instr_valid_o, .instr_o, .instr_pc_o,
    .bus_o (m1_bus)
  );

  wb_arbiter u_arb (
    .clk_i, .rst_i,
    .m0_i (m0_bus),
    .m1_i (m1_bus),
    .s_o  (ram_bus)
  );

  data_ram u_ram (
    .clk_i, .rst_i,
    .bus_i (ram_bus)
  );

endmodule : mem_subsys_top

// ==== tb_mem_subsys.sv ====
module tb_mem_subsys;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT   = 200;                    // Cycles per wait
  localparam int FETCH_SEG = 12;                     // Instructions between redirects

  typedef struct packed {
    logic                           is_load;
    logic                           wen;
    logic [core_pkg::REG_WIDTH-1:0] rd;
    logic [31:0]                    alu;
    logic [31:0]                    data;
  } wb_exp_t;

  logic                            clk_i = 1'b0;
  logic                            rst_i;
  logic [core_pkg::DATA_WIDTH-1:0] alu_result_i;
  logic [core_pkg::DATA_WIDTH-1:0] rs2_data_i;
  logic [core_pkg::REG_WIDTH-1:0]  wr_reg_i;
  logic                            valid_i;
  logic                            is_load_i;
  logic                            is_store_i;
  logic                            reg_wr_en_i;
  core_pkg::access_size_t          access_size_i;
  logic                            stall_o;
  logic                            wb_valid_o;
  logic                            wb_reg_wr_en_o;
  logic                            wb_is_load_o;
  logic                            wb_is_next_cycle_o;
  logic [core_pkg::REG_WIDTH-1:0]  wb_wr_reg_o;
  logic [core_pkg::DATA_WIDTH-1:0] wb_alu_result_o;
  logic [core_pkg::DATA_WIDTH-1:0] wb_load_data_o;
  logic                            fetch_en_i;
  logic                            redirect_i;
  logic                            instr_ready_i;
  logic [core_pkg::ADDR_WIDTH-1:0] redirect_pc_i;
  logic                            instr_valid_o;
  logic [core_pkg::DATA_WIDTH-1:0] instr_o;
  logic [core_pkg::ADDR_WIDTH-1:0] instr_pc_o;

  logic [7:0]  model [core_pkg::MEM_WORDS*4];        // Byte image of data_ram
  wb_exp_t     exp_q [$];
  logic [31:0] exp_pc = '0;                          // Fetch starts at 0 after reset
  logic        was_next = 1'b0;
  int          wb_errors = 0;
  int          fetch_errors = 0;
  int          timeouts = 0;
  int          fetch_seen = 0;

  mem_subsys_top dut0 (.*);

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] fill_word(input int i);
    return (32'(i) * 32'h9e37_79b9) ^ {4{8'(i)}};
  endfunction

  function automatic logic [31:0] load_ref(input logic [31:0] a,
                                           input core_pkg::access_size_t sz);
    logic [core_pkg::MEM_AW-1:0] w;
    logic [7:0]                  lo;
    logic [7:0]                  hi;
    w = a[core_pkg::MEM_AW+1:2];
    case (sz)
      core_pkg::SIZE_BYTE: begin
        lo = model[{w, a[1:0]}];
        return {{24{lo[7]}}, lo};
      end
      core_pkg::SIZE_HALF: begin
        lo = model[{w, a[1], 1'b0}];                 // Bit 0 ignored
        hi = model[{w, a[1], 1'b1}];
        return {{16{hi[7]}}, hi, lo};
      end
      default: return {model[{w, 2'd3}], model[{w, 2'd2}], model[{w, 2'd1}], model[{w, 2'd0}]};
    endcase
  endfunction

  task automatic store_model(input logic [31:0] a, input core_pkg::access_size_t sz,
                             input logic [31:0] d);
    logic [core_pkg::MEM_AW-1:0] w;
    w = a[core_pkg::MEM_AW+1:2];
    case (sz)
      core_pkg::SIZE_BYTE: model[{w, a[1:0]}] = d[7:0];
      core_pkg::SIZE_HALF: begin
        model[{w, a[1], 1'b0}] = d[7:0];
        model[{w, a[1], 1'b1}] = d[15:8];
      end
      default: begin
        for (int k = 0; k < 4; k++) model[{w, 2'(k)}] = d[8*k +: 8];
      end
    endcase
  endtask

  // One operation through the memory stage from drive to writeback
  task automatic mem_op(input logic ld, input logic st, input core_pkg::access_size_t sz,
                        input logic [31:0] a, input logic [31:0] d);
    wb_exp_t e;
    logic    wen;
    int      n;
    wen       = 1'($urandom);
    e.is_load = ld;
    e.wen     = ld ? 1'b1 : (st ? 1'b0 : wen);
    e.rd      = core_pkg::REG_WIDTH'($urandom);
    e.alu     = a;
    e.data    = ld ? load_ref(a, sz) : '0;
    if (st) store_model(a, sz, d);
    exp_q.push_back(e);
    alu_result_i  <= a;
    rs2_data_i    <= d;
    wr_reg_i      <= e.rd;
    is_load_i     <= ld;
    is_store_i    <= st;
    reg_wr_en_i   <= wen;
    access_size_i <= sz;
    valid_i       <= 1'b1;
    @(posedge clk_i);
    if (stall_o !== (ld || st)) begin                // Only loads and stores stall
      wb_errors++;
      $display("FAILED at %0t: stall_o %b on a new operation (load %b store %b)",
               $time, stall_o, ld, st);
    end
    n = 0;
    while (stall_o && n < TIMEOUT) begin
      @(posedge clk_i);
      n++;
    end
    if (stall_o) begin
      timeouts++;
      $display("timeout waiting for the memory stage to release stall_o at %0t", $time);
    end
    valid_i <= 1'b0;
    @(posedge clk_i);
    if (wb_valid_o !== 1'b1) begin
      wb_errors++;
      $display("FAILED at %0t: wb_valid_o not high one cycle after acceptance", $time);
    end
  endtask

  task automatic run_fetch();
    int          got;
    int          n;
    logic [31:0] target;
    fetch_en_i <= 1'b1;
    for (int seg = 0; seg < 3; seg++) begin
      got = 0;
      n   = 0;
      while (got < FETCH_SEG && n < 4 * TIMEOUT) begin
        @(posedge clk_i);
        if (instr_valid_o && instr_ready_i) got++;
        instr_ready_i <= ($urandom % 4) != 0;        // Random back-pressure
        n++;
      end
      if (got < FETCH_SEG) begin
        timeouts++;
        $display("timeout waiting for fetched instructions at %0t", $time);
      end
      target = ($urandom % 32) * 4;                  // Low words are never stored to
      redirect_pc_i <= target;
      redirect_i    <= 1'b1;
      @(posedge clk_i);
      redirect_i <= 1'b0;
    end
    fetch_en_i    <= 1'b0;
    instr_ready_i <= 1'b0;
  endtask

  always @(posedge clk_i) begin : compare
    wb_exp_t e;
    if (rst_i) begin
      if (wb_valid_o !== was_next) begin
        wb_errors++;
        $display("FAILED at %0t: wb_is_next_cycle_o %b one cycle before wb_valid_o %b",
                 $time, was_next, wb_valid_o);
      end
      if (wb_valid_o) begin
        if (exp_q.size() == 0) begin
          wb_errors++;
          $display("FAILED at %0t: wb_valid_o with no operation outstanding", $time);
        end else begin
          e = exp_q.pop_front();
          if (wb_alu_result_o !== e.alu || wb_wr_reg_o !== e.rd ||
              wb_reg_wr_en_o !== e.wen || wb_is_load_o !== e.is_load) begin
            wb_errors++;
            $display("FAILED at %0t: writeback %h rd %0d wen %b load %b, expected %h %0d %b %b",
                     $time, wb_alu_result_o, wb_wr_reg_o, wb_reg_wr_en_o, wb_is_load_o,
                     e.alu, e.rd, e.wen, e.is_load);
          end
          if (e.is_load && wb_load_data_o !== e.data) begin
            wb_errors++;
            $display("FAILED at %0t: load at %h returned %h, expected %h",
                     $time, e.alu, wb_load_data_o, e.data);
          end
        end
      end
      was_next = wb_is_next_cycle_o;
      if (instr_valid_o && instr_ready_i) begin
        fetch_seen++;
        if (instr_pc_o !== exp_pc || instr_o !== load_ref(exp_pc, core_pkg::SIZE_WORD)) begin
          fetch_errors++;
          $display("FAILED at %0t: fetched %h at pc %h, expected %h at pc %h", $time,
                   instr_o, instr_pc_o, load_ref(exp_pc, core_pkg::SIZE_WORD), exp_pc);
        end
        exp_pc = exp_pc + 32'd4;
      end
      if (redirect_i) exp_pc = redirect_pc_i;
    end
  end

  initial begin : main
    logic [31:0] a;
    void'($urandom(32'hb1ade26b));
    rst_i         = 1'b0;
    alu_result_i  = '0;
    rs2_data_i    = '0;
    wr_reg_i      = '0;
    valid_i       = 1'b0;
    is_load_i     = 1'b0;
    is_store_i    = 1'b0;
    reg_wr_en_i   = 1'b0;
    access_size_i = core_pkg::SIZE_WORD;
    fetch_en_i    = 1'b0;
    redirect_i    = 1'b0;
    instr_ready_i = 1'b0;
    redirect_pc_i = '0;
    repeat (10) @(posedge clk_i);
    rst_i <= 1'b1;
    @(posedge clk_i);
    if (wb_valid_o !== 1'b0 || stall_o !== 1'b0 || instr_valid_o !== 1'b0) begin
      wb_errors++;
      $display("FAILED at %0t: outputs not low after reset", $time);
    end
    repeat (2) @(posedge clk_i);
    for (int i = 0; i < core_pkg::MEM_WORDS; i++) begin   // Fill RAM and model alike
      mem_op(1'b0, 1'b1, core_pkg::SIZE_WORD, 32'(i) << 2, fill_word(i));
    end
    repeat (10) mem_op(1'b0, 1'b0, core_pkg::SIZE_WORD, $urandom, $urandom);
    repeat (40) begin
      a = 32'h200 + ($urandom % 32'h200);            // Upper half holds data only
      mem_op(1'b0, 1'b1, core_pkg::access_size_t'($urandom % 3), a, $urandom);
      mem_op(1'b1, 1'b0, core_pkg::SIZE_WORD, a, $urandom);
    end
    repeat (8) begin
      a = ($urandom % 32'h400) & ~32'h3;
      for (int lane = 0; lane < 4; lane++) begin
        mem_op(1'b1, 1'b0, core_pkg::SIZE_BYTE, a + 32'(lane), $urandom);
        mem_op(1'b1, 1'b0, core_pkg::SIZE_HALF, a + 32'(lane), $urandom);
      end
    end
    fork
      run_fetch();
      repeat (60) begin
        a = 32'h200 + ($urandom % 32'h200);
        mem_op(1'b0, 1'b1, core_pkg::access_size_t'($urandom % 3), a, $urandom);
        mem_op(1'b1, 1'b0, core_pkg::access_size_t'($urandom % 3), a, $urandom);
      end
    join
    repeat (4) @(posedge clk_i);
    if (exp_q.size() != 0) begin
      wb_errors++;
      $display("%0d writeback results never arrived", exp_q.size());
    end
    if (fetch_seen < 3 * FETCH_SEG) begin
      fetch_errors++;
      $display("only %0d instructions were accepted from the fetch unit", fetch_seen);
    end
    $display("errors: writeback %0d, fetch %0d, timeouts %0d",
             wb_errors, fetch_errors, timeouts);
    if (wb_errors + fetch_errors + timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule : tb_mem_subsys

// ==== wb_arbiter.sv ====
module wb_arbiter (
  input  logic clk_i,
  input  logic rst_i,
  wb_if.slave  m0_i,
  wb_if.slave  m1_i,
  wb_if.master s_o
);

  logic locked;       // A cycle is open on the slave
  logic gnt_q;
  logic last_q;       // Master served last
  logic owner;
  logic owner_cyc;

  always_comb begin
    if (locked)                 owner = gnt_q;
    else if (m0_i.cyc && m1_i.cyc) owner = !last_q;
    else                        owner = m1_i.cyc;
  end

  assign owner_cyc = owner ? m1_i.cyc : m0_i.cyc;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      locked <= 1'b0;
      gnt_q  <= 1'b0;
      last_q <= 1'b1;                            // Master 0 wins the first tie
    end else begin
      locked <= owner_cyc && !s_o.ack;           // Master drops cyc after ack
      if (!locked && owner_cyc) begin
        gnt_q  <= owner;
        last_q <= owner;
      end
    end
  end

  assign s_o.cyc   = owner ? m1_i.cyc   : m0_i.cyc;
  assign s_o.stb   = owner ? m1_i.stb   : m0_i.stb;
  assign s_o.we    = owner ? m1_i.we    : m0_i.we;
  assign s_o.adr   = owner ? m1_i.adr   : m0_i.adr;
  assign s_o.sel   = owner ? m1_i.sel   : m0_i.sel;
  assign s_o.dat_w = owner ? m1_i.dat_w : m0_i.dat_w;

  assign m0_i.ack   = s_o.ack && !owner;
  assign m1_i.ack   = s_o.ack && owner;
  assign m0_i.dat_r = owner ? '0 : s_o.dat_r;
  assign m1_i.dat_r = owner ? s_o.dat_r : '0;

endmodule : wb_arbiter

// ==== wb_if.sv ====
interface wb_if;

  logic                            cyc;
  logic                            stb;
  logic                            we;
  logic [core_pkg::ADDR_WIDTH-1:0] adr;    // Byte address
  logic [core_pkg::SEL_WIDTH-1:0]  sel;
  logic [core_pkg::DATA_WIDTH-1:0] dat_w;
  logic [core_pkg::DATA_WIDTH-1:0] dat_r;
  logic                            ack;

  modport master (
    output cyc, stb, we, adr, sel, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, sel, dat_w,
    output dat_r, ack
  );

endinterface : wb_if
